/* dv/noc_tb.sv */
// Self-checking testbench that routes flits across the 3x3 mesh through its edge ports
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module noc_tb;

    localparam int rx_timeout  = 400;
    localparam int idle_window = 200;
    localparam int num_cases   = 15;

    // One table row, sides use the router direction codes
    typedef struct packed {
        logic [1:0] in_side;
        logic [1:0] in_sel;
        logic [2:0] dest_x;
        logic [2:0] dest_y;
        logic [1:0] out_side;
        logic [1:0] out_sel;
        logic       drop;
        logic       paired;
    } case_t;

    // Exits follow XY order, so a west or east exit keeps the row the flit entered on
    localparam case_t case_tab [num_cases] = '{
        '{noc_pkg::dir_west,  2'd0, 3'd4, 3'd1, noc_pkg::dir_east,  2'd0, 1'b0, 1'b0},
        '{noc_pkg::dir_west,  2'd2, 3'd4, 3'd3, noc_pkg::dir_east,  2'd2, 1'b0, 1'b0},
        '{noc_pkg::dir_south, 2'd1, 3'd2, 3'd4, noc_pkg::dir_north, 2'd1, 1'b0, 1'b0},
        '{noc_pkg::dir_south, 2'd0, 3'd4, 3'd1, noc_pkg::dir_east,  2'd0, 1'b0, 1'b0},
        '{noc_pkg::dir_west,  2'd0, 3'd3, 3'd4, noc_pkg::dir_north, 2'd2, 1'b0, 1'b0},
        '{noc_pkg::dir_east,  2'd1, 3'd1, 3'd0, noc_pkg::dir_south, 2'd0, 1'b0, 1'b0},
        '{noc_pkg::dir_north, 2'd2, 3'd0, 3'd3, noc_pkg::dir_west,  2'd2, 1'b0, 1'b0},
        '{noc_pkg::dir_south, 2'd0, 3'd3, 3'd0, noc_pkg::dir_south, 2'd2, 1'b0, 1'b0},
        '{noc_pkg::dir_north, 2'd0, 3'd3, 3'd4, noc_pkg::dir_north, 2'd2, 1'b0, 1'b0},
        '{noc_pkg::dir_west,  2'd1, 3'd0, 3'd2, noc_pkg::dir_west,  2'd1, 1'b0, 1'b0},
        // Two sides racing for the same exit
        '{noc_pkg::dir_west,  2'd0, 3'd3, 3'd4, noc_pkg::dir_north, 2'd2, 1'b0, 1'b1},
        '{noc_pkg::dir_east,  2'd2, 3'd3, 3'd4, noc_pkg::dir_north, 2'd2, 1'b0, 1'b0},
        // Exit pins gated off, then pointed at the wrong position
        '{noc_pkg::dir_west,  2'd1, 3'd4, 3'd2, noc_pkg::dir_east,  2'd3, 1'b1, 1'b0},
        '{noc_pkg::dir_west,  2'd1, 3'd4, 3'd2, noc_pkg::dir_east,  2'd0, 1'b1, 1'b0},
        // Inner router destination
        '{noc_pkg::dir_west,  2'd1, 3'd2, 3'd2, noc_pkg::dir_west,  2'd3, 1'b1, 1'b0}
    };

    logic             clk;
    logic             rst_n;
    logic [1:0]       west_sel;
    logic [1:0]       south_sel;
    logic [1:0]       east_sel;
    logic [1:0]       north_sel;
    noc_pkg::nibble_t in_west;
    noc_pkg::nibble_t in_south;
    noc_pkg::nibble_t in_east;
    noc_pkg::nibble_t in_north;
    noc_pkg::nibble_t out_west;
    noc_pkg::nibble_t out_south;
    noc_pkg::nibble_t out_east;
    noc_pkg::nibble_t out_north;

    integer seed;

    noc_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .west_sel  (west_sel),
        .south_sel (south_sel),
        .east_sel  (east_sel),
        .north_sel (north_sel),
        .in_west   (in_west),
        .in_south  (in_south),
        .in_east   (in_east),
        .in_north  (in_north),
        .out_west  (out_west),
        .out_south (out_south),
        .out_east  (out_east),
        .out_north (out_north)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==========================================================
    // Pin access and checks
    // ==========================================================
    // Drive and sample point, just after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic noc_pkg::nibble_t side_out(input logic [1:0] side);
        case (side)
            noc_pkg::dir_north: return out_north;
            noc_pkg::dir_east:  return out_east;
            noc_pkg::dir_south: return out_south;
            default:            return out_west;
        endcase
    endfunction

    function automatic string side_name(input logic [1:0] side);
        case (side)
            noc_pkg::dir_north: return "out_north";
            noc_pkg::dir_east:  return "out_east";
            noc_pkg::dir_south: return "out_south";
            default:            return "out_west";
        endcase
    endfunction

    task automatic drive_in(input logic [1:0] side, input noc_pkg::nibble_t n);
        case (side)
            noc_pkg::dir_north: in_north = n;
            noc_pkg::dir_east:  in_east  = n;
            noc_pkg::dir_south: in_south = n;
            default:            in_west  = n;
        endcase
    endtask

    task automatic set_sel(input logic [1:0] side, input logic [1:0] sel);
        case (side)
            noc_pkg::dir_north: north_sel = sel;
            noc_pkg::dir_east:  east_sel  = sel;
            noc_pkg::dir_south: south_sel = sel;
            default:            west_sel  = sel;
        endcase
    endtask

    // Pin data is don't-care while valid is low
    task automatic check_nibble(input string name, input noc_pkg::nibble_t got,
                                input noc_pkg::nibble_t exp);
        if (got.valid !== exp.valid || (exp.valid && got.data !== exp.data)) begin
            fail_run($sformatf("error %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flit(input string name, input noc_pkg::flit_t got,
                              input noc_pkg::flit_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_all_idle();
        for (int s = 0; s < 4; s++) begin
            check_nibble(side_name(2'(s)), side_out(2'(s)), '0);
        end
    endtask

    // ==========================================================
    // Stimulus and collection
    // ==========================================================
    task automatic build_flit(input case_t c, output noc_pkg::flit_t f);
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        f.dest_x  = c.dest_x;
        f.dest_y  = c.dest_y;
        f.payload = r[noc_pkg::payload_w-1:0];
    endtask

    // Shift in one or two flits side by side, then open the exit pins
    task automatic send_flits(input case_t c0, input noc_pkg::flit_t f0, input logic two,
                              input case_t c1, input noc_pkg::flit_t f1);
        logic [`NOC_FLIT_W-1:0] b0;
        logic [`NOC_FLIT_W-1:0] b1;
        b0 = f0;
        b1 = f1;
        tick();
        set_sel(c0.in_side, c0.in_sel);
        if (two) begin
            set_sel(c1.in_side, c1.in_sel);
        end
        for (int b = 0; b < `NOC_BEATS; b++) begin
            drive_in(c0.in_side, {1'b1, b0[b*`NOC_NIB_W +: `NOC_NIB_W]});
            if (two) begin
                drive_in(c1.in_side, {1'b1, b1[b*`NOC_NIB_W +: `NOC_NIB_W]});
            end
            tick();
        end
        for (int s = 0; s < 4; s++) begin
            drive_in(2'(s), '0);
            set_sel(2'(s), 2'(`NOC_SEL_NONE));
        end
        set_sel(c0.out_side, c0.out_sel);
    endtask

    task automatic receive_flit(input logic [1:0] side, output noc_pkg::flit_t f);
        logic [`NOC_FLIT_W-1:0] bits;
        noc_pkg::nibble_t       n;
        int                     cnt;
        cnt = 0;
        tick();
        n = side_out(side);
        while (n.valid !== 1'b1) begin
            if (cnt >= rx_timeout) begin
                fail_run($sformatf("timed out waiting for a flit on %s", side_name(side)));
            end
            cnt++;
            tick();
            n = side_out(side);
        end
        for (int b = 0; b < `NOC_BEATS; b++) begin
            n = side_out(side);
            if (n.valid !== 1'b1) begin
                fail_run($sformatf("%s valid fell after %0d nibbles", side_name(side), b));
            end
            bits[b*`NOC_NIB_W +: `NOC_NIB_W] = n.data;
            tick();
        end
        // Burst must end after exactly 16 nibbles
        check_nibble(side_name(side), side_out(side), '0);
        f = noc_pkg::flit_t'(bits);
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        noc_pkg::flit_t f0;
        noc_pkg::flit_t f1;
        noc_pkg::flit_t r0;
        noc_pkg::flit_t r1;
        int             idx;
        seed      = 32'h79489b85;
        rst_n     = 1'b0;
        west_sel  = 2'(`NOC_SEL_NONE);
        south_sel = 2'(`NOC_SEL_NONE);
        east_sel  = 2'(`NOC_SEL_NONE);
        north_sel = 2'(`NOC_SEL_NONE);
        in_west   = '0;
        in_south  = '0;
        in_east   = '0;
        in_north  = '0;
        repeat (5) tick();
        rst_n = 1'b1;

        for (int c = 0; c < 20; c++) begin
            tick();
            check_all_idle();
        end

        idx = 0;
        while (idx < num_cases) begin
            build_flit(case_tab[idx], f0);
            if (case_tab[idx].paired) begin
                build_flit(case_tab[idx+1], f1);
                send_flits(case_tab[idx], f0, 1'b1, case_tab[idx+1], f1);
                receive_flit(case_tab[idx].out_side, r0);
                receive_flit(case_tab[idx].out_side, r1);
                // Arrival order depends on arbitration
                if (r0 === f0) begin
                    check_flit("second flit", r1, f1);
                end else begin
                    check_flit("first flit", r0, f1);
                    check_flit("second flit", r1, f0);
                end
                idx += 2;
            end else begin
                send_flits(case_tab[idx], f0, 1'b0, case_tab[idx], f0);
                if (case_tab[idx].drop) begin
                    for (int c = 0; c < idle_window; c++) begin
                        tick();
                        check_all_idle();
                    end
                end else begin
                    receive_flit(case_tab[idx].out_side, r0);
                    check_flit("flit", r0, f0);
                end
                idx++;
            end
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/edge_port.sv */
// Mesh side port with select steering over three edge positions
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module edge_port (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire [1:0]             sel,
    input  wire noc_pkg::nibble_t nib_in,
    output noc_pkg::nibble_t      nib_out,
    output noc_pkg::link_t        to_mesh   [`NOC_DIM],
    input  wire noc_pkg::link_t   from_mesh [`NOC_DIM],
    output logic                  ser_busy  [`NOC_DIM]
);

    noc_pkg::nibble_t des_nib [`NOC_DIM];
    noc_pkg::nibble_t ser_nib [`NOC_DIM];

    // ==========================================================
    // One deserializer and one serializer per edge position
    // ==========================================================
    for (genvar k = 0; k < `NOC_DIM; k++) begin : g_pos
        // Only the selected position sees input strobes
        assign des_nib[k].valid = nib_in.valid && (sel == 2'(k));
        assign des_nib[k].data  = nib_in.data;

        flit_deserializer u_des (
            .clk      (clk),
            .rst_n    (rst_n),
            .nib      (des_nib[k]),
            .flit_out (to_mesh[k])
        );

        flit_serializer u_ser (
            .clk     (clk),
            .rst_n   (rst_n),
            .flit_in (from_mesh[k]),
            .busy    (ser_busy[k]),
            .nib     (ser_nib[k])
        );
    end

    // Output pins follow the selected serializer, idle otherwise
    always_comb begin
        nib_out = '0;
        if (sel != 2'(`NOC_SEL_NONE)) begin
            nib_out = ser_nib[sel];
        end
    end

endmodule

`default_nettype wire

/* hdl/flit_deserializer.sv */
// Flit deserializer that gathers sixteen edge nibbles into one flit
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module flit_deserializer (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire noc_pkg::nibble_t nib,
    output noc_pkg::link_t        flit_out
);

    localparam int cnt_w = $clog2(`NOC_BEATS);

    logic [cnt_w-1:0]       beat_cnt;
    logic [`NOC_FLIT_W-1:0] shift_q;
    logic                   done_q;

    // Beat counter, pulses done after the last nibble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (nib.valid) begin
                if (beat_cnt == cnt_w'(`NOC_BEATS - 1)) begin
                    beat_cnt <= '0;
                    done_q   <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // New nibbles enter at the top so the first ends in bits 3:0
    always_ff @(posedge clk) begin
        if (nib.valid) begin
            shift_q <= {nib.data, shift_q[`NOC_FLIT_W-1:`NOC_NIB_W]};
        end
    end

    assign flit_out.valid = done_q;
    assign flit_out.flit  = noc_pkg::flit_t'(shift_q);

endmodule

`default_nettype wire

/* hdl/flit_serializer.sv */
// Flit serializer that shifts a flit out to the edge pins nibble by nibble
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module flit_serializer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire noc_pkg::link_t flit_in,
    output logic                busy,
    output noc_pkg::nibble_t    nib
);

    localparam int cnt_w = $clog2(`NOC_BEATS);

    logic [cnt_w-1:0]       beat_cnt;
    logic [`NOC_FLIT_W-1:0] shift_q;
    logic                   active_q;
    logic                   load;

    // A flit is taken only while idle
    assign load = flit_in.valid && !active_q;

    // Shift control, active for exactly one nibble per beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            beat_cnt <= '0;
        end else if (load) begin
            active_q <= 1'b1;
            beat_cnt <= '0;
        end else if (active_q) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == cnt_w'(`NOC_BEATS - 1)) begin
                active_q <= 1'b0;
            end
        end
    end

    // Least significant nibble leaves first
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= flit_in.flit;
        end else if (active_q) begin
            shift_q <= {{`NOC_NIB_W{1'b0}}, shift_q[`NOC_FLIT_W-1:`NOC_NIB_W]};
        end
    end

    // Held high through the last nibble, so bursts never merge
    assign busy      = active_q;
    assign nib.valid = active_q;
    assign nib.data  = shift_q[`NOC_NIB_W-1:0];

endmodule

`default_nettype wire

/* hdl/mesh_router.sv */
// XY mesh router with one-flit input buffers and fixed-priority output arbitration
`timescale 1ns/1ps
`default_nettype none

module mesh_router #(
    parameter int router_x = 1,
    parameter int router_y = 1
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire noc_pkg::link_t link_in  [4],
    output logic                full_out [4],
    output noc_pkg::link_t      link_out [4],
    input  wire                 full_in  [4]
);

    localparam int num_dirs = 4;

    noc_pkg::flit_t      buf_q  [num_dirs];
    logic [num_dirs-1:0] buf_v;
    // Request and grant vectors, indexed [output][input]
    logic [num_dirs-1:0] req    [num_dirs];
    logic [num_dirs-1:0] gnt    [num_dirs];
    logic [num_dirs-1:0] drop;
    logic [num_dirs-1:0] served;
    logic [num_dirs-1:0] out_free;
    logic [num_dirs-1:0] out_v;
    noc_pkg::flit_t      out_q  [num_dirs];
    noc_pkg::flit_t      out_d  [num_dirs];

    // ==========================================================
    // Route decision, X first then Y
    // ==========================================================
    always_comb begin
        drop = '0;
        for (int o = 0; o < num_dirs; o++) begin
            req[o] = '0;
        end
        for (int i = 0; i < num_dirs; i++) begin
            if (buf_v[i]) begin
                if (buf_q[i].dest_x > router_x) begin
                    req[noc_pkg::dir_east][i] = 1'b1;
                end else if (buf_q[i].dest_x < router_x) begin
                    req[noc_pkg::dir_west][i] = 1'b1;
                end else if (buf_q[i].dest_y > router_y) begin
                    req[noc_pkg::dir_north][i] = 1'b1;
                end else if (buf_q[i].dest_y < router_y) begin
                    req[noc_pkg::dir_south][i] = 1'b1;
                end else begin
                    // Addressed to this inner router, nothing to deliver to
                    drop[i] = 1'b1;
                end
            end
        end
    end

    // ==========================================================
    // Arbitration, lowest input index wins
    // ==========================================================
    always_comb begin
        for (int o = 0; o < num_dirs; o++) begin
            // Free when empty or handed downstream this cycle
            out_free[o] = !out_v[o] || !full_in[o];
            gnt[o]      = out_free[o] ? (req[o] & (~req[o] + 1'b1)) : '0;
            out_d[o]    = buf_q[0];
            for (int i = 0; i < num_dirs; i++) begin
                if (gnt[o][i]) begin
                    out_d[o] = buf_q[i];
                end
            end
        end
        for (int i = 0; i < num_dirs; i++) begin
            served[i] = drop[i];
            for (int o = 0; o < num_dirs; o++) begin
                served[i] = served[i] | gnt[o][i];
            end
        end
    end

    // Buffer and output occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_v <= '0;
            out_v <= '0;
        end else begin
            for (int i = 0; i < num_dirs; i++) begin
                if (buf_v[i]) begin
                    if (served[i]) begin
                        buf_v[i] <= 1'b0;
                    end
                end else if (link_in[i].valid) begin
                    buf_v[i] <= 1'b1;
                end
            end
            for (int o = 0; o < num_dirs; o++) begin
                if (gnt[o] != '0) begin
                    out_v[o] <= 1'b1;
                end else if (!full_in[o]) begin
                    out_v[o] <= 1'b0;
                end
            end
        end
    end

    // Flit storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_dirs; i++) begin
            if (!buf_v[i] && link_in[i].valid) begin
                buf_q[i] <= link_in[i].flit;
            end
        end
        for (int o = 0; o < num_dirs; o++) begin
            if (gnt[o] != '0) begin
                out_q[o] <= out_d[o];
            end
        end
    end

    always_comb begin
        for (int d = 0; d < num_dirs; d++) begin
            full_out[d]       = buf_v[d];
            link_out[d].valid = out_v[d];
            link_out[d].flit  = out_q[d];
        end
    end

endmodule

`default_nettype wire

/* hdl/noc_macros.svh */
// Mesh size, flit and edge nibble constants for the 3x3 mesh network
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// ==========================================================
// Mesh geometry
// ==========================================================

// Routers per row and per column
`define NOC_DIM      3
// One coordinate, edges at 0 and 4
`define NOC_COORD_W  3

// ==========================================================
// Flit and edge pin widths
// ==========================================================

`define NOC_FLIT_W   64
`define NOC_NIB_W    4
`define NOC_BEATS    16

// Side select that leaves the pins unconnected
`define NOC_SEL_NONE 3

`endif

/* hdl/noc_pkg.sv */
// Flit, link, nibble and direction types shared across the mesh network
`default_nettype none

`include "noc_macros.svh"

package noc_pkg;

    // Bits left for payload after both destination coordinates
    localparam int payload_w = `NOC_FLIT_W - 2 * `NOC_COORD_W;

    // Destination sits in the top bits of the flit
    typedef struct packed {
        logic [`NOC_COORD_W-1:0] dest_x;
        logic [`NOC_COORD_W-1:0] dest_y;
        logic [payload_w-1:0]    payload;
    } flit_t;

    // One flit on a router or edge link
    typedef struct packed {
        logic  valid;
        flit_t flit;
    } link_t;

    // Pin pair of one mesh side
    typedef struct packed {
        logic                  valid;
        logic [`NOC_NIB_W-1:0] data;
    } nibble_t;

    // Router port index
    typedef enum logic [1:0] {
        dir_north = 2'd0,
        dir_east  = 2'd1,
        dir_south = 2'd2,
        dir_west  = 2'd3
    } dir_e;

endpackage

`default_nettype wire

/* hdl/noc_top.sv */
// 3x3 mesh network top with nibble-serial edge ports on all four sides
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module noc_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire [1:0]             west_sel,
    input  wire [1:0]             south_sel,
    input  wire [1:0]             east_sel,
    input  wire [1:0]             north_sel,
    input  wire noc_pkg::nibble_t in_west,
    input  wire noc_pkg::nibble_t in_south,
    input  wire noc_pkg::nibble_t in_east,
    input  wire noc_pkg::nibble_t in_north,
    output noc_pkg::nibble_t      out_west,
    output noc_pkg::nibble_t      out_south,
    output noc_pkg::nibble_t      out_east,
    output noc_pkg::nibble_t      out_north
);

    // Side arrays are indexed by direction
    logic [1:0]       side_sel  [4];
    noc_pkg::nibble_t side_in   [4];
    noc_pkg::nibble_t side_out  [4];
    noc_pkg::link_t   edge_to   [4][`NOC_DIM];
    noc_pkg::link_t   edge_from [4][`NOC_DIM];
    logic             edge_busy [4][`NOC_DIM];

    // Router grid, indexed [x-1][y-1][port]
    noc_pkg::link_t   rlink_in  [`NOC_DIM][`NOC_DIM][4];
    noc_pkg::link_t   rlink_out [`NOC_DIM][`NOC_DIM][4];
    logic             rfull_in  [`NOC_DIM][`NOC_DIM][4];
    logic             rfull_out [`NOC_DIM][`NOC_DIM][4];

    assign side_sel[noc_pkg::dir_west]  = west_sel;
    assign side_sel[noc_pkg::dir_south] = south_sel;
    assign side_sel[noc_pkg::dir_east]  = east_sel;
    assign side_sel[noc_pkg::dir_north] = north_sel;
    assign side_in[noc_pkg::dir_west]   = in_west;
    assign side_in[noc_pkg::dir_south]  = in_south;
    assign side_in[noc_pkg::dir_east]   = in_east;
    assign side_in[noc_pkg::dir_north]  = in_north;
    assign out_west  = side_out[noc_pkg::dir_west];
    assign out_south = side_out[noc_pkg::dir_south];
    assign out_east  = side_out[noc_pkg::dir_east];
    assign out_north = side_out[noc_pkg::dir_north];

    // ==========================================================
    // Edge ports, position k sits on row or column k+1
    // ==========================================================
    for (genvar s = 0; s < 4; s++) begin : g_side
        edge_port u_edge (
            .clk       (clk),
            .rst_n     (rst_n),
            .sel       (side_sel[s]),
            .nib_in    (side_in[s]),
            .nib_out   (side_out[s]),
            .to_mesh   (edge_to[s]),
            .from_mesh (edge_from[s]),
            .ser_busy  (edge_busy[s])
        );
    end

    for (genvar k = 0; k < `NOC_DIM; k++) begin : g_exit
        assign edge_from[noc_pkg::dir_west][k]  = rlink_out[0][k][noc_pkg::dir_west];
        assign edge_from[noc_pkg::dir_east][k]  = rlink_out[`NOC_DIM-1][k][noc_pkg::dir_east];
        assign edge_from[noc_pkg::dir_south][k] = rlink_out[k][0][noc_pkg::dir_south];
        assign edge_from[noc_pkg::dir_north][k] = rlink_out[k][`NOC_DIM-1][noc_pkg::dir_north];
    end

    // ==========================================================
    // Router grid and neighbour links
    // ==========================================================
    for (genvar gx = 0; gx < `NOC_DIM; gx++) begin : g_col
        for (genvar gy = 0; gy < `NOC_DIM; gy++) begin : g_row
            if (gy == `NOC_DIM - 1) begin : g_n_edge
                assign rlink_in[gx][gy][noc_pkg::dir_north] = edge_to[noc_pkg::dir_north][gx];
                assign rfull_in[gx][gy][noc_pkg::dir_north] = edge_busy[noc_pkg::dir_north][gx];
            end else begin : g_n_link
                assign rlink_in[gx][gy][noc_pkg::dir_north] =
                    rlink_out[gx][gy+1][noc_pkg::dir_south];
                assign rfull_in[gx][gy][noc_pkg::dir_north] =
                    rfull_out[gx][gy+1][noc_pkg::dir_south];
            end
            if (gy == 0) begin : g_s_edge
                assign rlink_in[gx][gy][noc_pkg::dir_south] = edge_to[noc_pkg::dir_south][gx];
                assign rfull_in[gx][gy][noc_pkg::dir_south] = edge_busy[noc_pkg::dir_south][gx];
            end else begin : g_s_link
                assign rlink_in[gx][gy][noc_pkg::dir_south] =
                    rlink_out[gx][gy-1][noc_pkg::dir_north];
                assign rfull_in[gx][gy][noc_pkg::dir_south] =
                    rfull_out[gx][gy-1][noc_pkg::dir_north];
            end
            if (gx == `NOC_DIM - 1) begin : g_e_edge
                assign rlink_in[gx][gy][noc_pkg::dir_east] = edge_to[noc_pkg::dir_east][gy];
                assign rfull_in[gx][gy][noc_pkg::dir_east] = edge_busy[noc_pkg::dir_east][gy];
            end else begin : g_e_link
                assign rlink_in[gx][gy][noc_pkg::dir_east] =
                    rlink_out[gx+1][gy][noc_pkg::dir_west];
                assign rfull_in[gx][gy][noc_pkg::dir_east] =
                    rfull_out[gx+1][gy][noc_pkg::dir_west];
            end
            if (gx == 0) begin : g_w_edge
                assign rlink_in[gx][gy][noc_pkg::dir_west] = edge_to[noc_pkg::dir_west][gy];
                assign rfull_in[gx][gy][noc_pkg::dir_west] = edge_busy[noc_pkg::dir_west][gy];
            end else begin : g_w_link
                assign rlink_in[gx][gy][noc_pkg::dir_west] =
                    rlink_out[gx-1][gy][noc_pkg::dir_east];
                assign rfull_in[gx][gy][noc_pkg::dir_west] =
                    rfull_out[gx-1][gy][noc_pkg::dir_east];
            end

            mesh_router #(
                .router_x (gx + 1),
                .router_y (gy + 1)
            ) u_router (
                .clk      (clk),
                .rst_n    (rst_n),
                .link_in  (rlink_in[gx][gy]),
                .full_out (rfull_out[gx][gy]),
                .link_out (rlink_out[gx][gy]),
                .full_in  (rfull_in[gx][gy])
            );
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/noc_pkg.sv
hdl/flit_deserializer.sv
hdl/flit_serializer.sv
hdl/edge_port.sv
hdl/mesh_router.sv
hdl/noc_top.sv
dv/noc_tb.sv
